//--- build.f
design/ibufPkg.sv
design/irqLatch.sv
design/stallGen.sv
design/instrDecode.sv
design/ibufTop.sv
tb/ibuf_asserts.sv
tb/ibufTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = ibufTb
FILELIST  = build.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, pass when the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

//--- tb/ibufTb.sv
`timescale 1ns/100ps
`default_nettype none

module ibufTb;

   localparam int SyncDepth = 2;
   localparam int ClkPeriod = 40;
   localparam logic [31:0] Seed = 32'hdf55_1c03;
   localparam int ResetCycles = 4;
   localparam int DecodeCycles = 200;
   localparam int ImmPairs = 24;
   localparam int RoundCycles = 10;
   localparam int IrqRounds = 8;
   localparam int StallRounds = 8;
   // Irq and disabled rounds, four blocking ops, stall rounds
   localparam int TestCycles = ResetCycles + DecodeCycles + 2 * ImmPairs
      + (2 * IrqRounds + 4 + StallRounds) * RoundCycles + 1;
   localparam logic [5:0] BlockOps [4] = '{ibufPkg::opImm, ibufPkg::opRtd,
      ibufPkg::opBru0, ibufPkg::opBcc1};
   localparam logic [5:0] SlowOps [4] = '{ibufPkg::opMul0, ibufPkg::opMul1,
      ibufPkg::opBsf0, ibufPkg::opBsf1};

   logic                     gclk;
   logic                     grst;
   logic [31:0]              iData;
   logic                     sysInt;
   logic                     msrIe;
   logic                     dEn;
   logic                     oEna;
   logic [ibufPkg::OpcW-1:0] opc;
   logic [ibufPkg::RegW-1:0] rd;
   logic [ibufPkg::RegW-1:0] ra;
   logic [ibufPkg::RegW-1:0] rb;
   logic [ibufPkg::AltW-1:0] alt;
   logic [ibufPkg::ImmW-1:0] imm;
   logic [31:0]              simm;
   logic [31:0]              ireg;
   logic                     fStall;

   // Reference state: sync chain, pending flag, registered word
   logic [SyncDepth-1:0] mSync;
   logic                 mPend;
   logic [31:0]          mWord;
   logic [31:0]          mSimm;
   logic [31:0]          lastIreg;
   string                testName;

   ibufTop #(
      .SYNC_DEPTH(SyncDepth)
   ) dut (
      .gclk  (gclk),
      .grst  (grst),
      .iData (iData),
      .sysInt(sysInt),
      .msrIe (msrIe),
      .dEn   (dEn),
      .oEna  (oEna),
      .opc   (opc),
      .rd    (rd),
      .ra    (ra),
      .rb    (rb),
      .alt   (alt),
      .imm   (imm),
      .simm  (simm),
      .ireg  (ireg),
      .fStall(fStall)
   );

   initial begin
      gclk = 1'b0;
      forever #(ClkPeriod / 2) gclk = ~gclk;
   end

   initial begin : watchdog
      #((TestCycles + 100) * ClkPeriod);
      $display("Simulation ran past its cycle budget without finishing");
      $display("TEST FAILED");
      $fatal(1, "Watchdog timeout");
   end

   // IMM pair, return and branches keep the fetched word
   function automatic logic blocksInject(input logic [5:0] op);
      return op == ibufPkg::opImm || op == ibufPkg::opRtd || op == ibufPkg::opBru0
         || op == ibufPkg::opBru1 || op == ibufPkg::opBcc0 || op == ibufPkg::opBcc1;
   endfunction

   function automatic logic [31:0] expectSel();
      if (mPend && !blocksInject(mWord[31:26])) begin
         return ibufPkg::intOp;
      end
      return iData;
   endfunction

   function automatic logic [31:0] ordinaryWord();
      logic [31:0] word;
      word = $urandom;
      while (blocksInject(word[31:26])) begin
         word = $urandom;
      end
      return word;
   endfunction

   always @(posedge gclk) begin : refModel
      logic [31:0] sel;
      logic        taken;
      sel = expectSel();
      taken = (mWord == ibufPkg::intOp);
      if (grst) begin
         mSync = '0;
         mPend = 1'b0;
         mWord = '0;
         mSimm = '0;
      end else begin
         // Pending uses the oldest stage before it shifts
         mPend = taken ? 1'b0 : (mPend | mSync[SyncDepth-1]) & msrIe;
         if (msrIe) begin
            mSync = {mSync[SyncDepth-2:0], sysInt};
         end
         if (dEn) begin
            if (mWord[31:26] == ibufPkg::opImm) begin
               mSimm = {mWord[15:0], sel[15:0]};
            end else begin
               mSimm = {{16{sel[15]}}, sel[15:0]};
            end
            mWord = sel;
         end
      end
   end

   task automatic checkValue(input string field, input logic [31:0] expected,
         input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Error %s.%s expected 0x%h actual 0x%h", testName, field, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic requireTrue(input logic cond, input string what);
      assert (cond) else begin
         $display("%s in %s", what, testName);
         $display("TEST FAILED");
         $fatal(1, "Check failed");
      end
   endtask

   task automatic checkOutputs();
      checkValue("opc", 32'(mWord[31:26]), 32'(opc));
      checkValue("rd", 32'(mWord[25:21]), 32'(rd));
      checkValue("ra", 32'(mWord[20:16]), 32'(ra));
      checkValue("rb", 32'(mWord[15:11]), 32'(rb));
      checkValue("alt", 32'(mWord[10:0]), 32'(alt));
      checkValue("imm", 32'(mWord[15:0]), 32'(imm));
      checkValue("simm", mSimm, simm);
      checkValue("ireg", expectSel(), ireg);
   endtask

   // Check on the falling edge, then drive the next inputs
   task automatic stepCycle(input logic [31:0] word, input logic den, input logic irq,
         input logic ie, input logic ena);
      @(negedge gclk);
      checkOutputs();
      lastIreg = ireg;
      iData = word;
      dEn = den;
      sysInt = irq;
      msrIe = ie;
      oEna = ena;
   endtask

   task automatic irqRound();
      logic found;
      int   i;
      found = 1'b0;
      stepCycle(ordinaryWord(), 1'b1, 1'b1, 1'b1, 1'b0);
      // Injection expected within the sync depth plus two
      for (i = 0; i < SyncDepth + 2 && !found; i++) begin
         stepCycle(ordinaryWord(), 1'b1, 1'b0, 1'b1, 1'b0);
         found = (lastIreg == ibufPkg::intOp);
      end
      requireTrue(found, "Interrupt word not injected in time");
      repeat (RoundCycles - SyncDepth - 3) stepCycle(ordinaryWord(), 1'b1, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic blockRound(input logic [5:0] op);
      logic [31:0] word;
      word = ordinaryWord();
      stepCycle({op, 26'($urandom)}, 1'b1, 1'b0, 1'b1, 1'b0);
      // Hold the blocking op while the request becomes pending
      stepCycle(word, 1'b0, 1'b1, 1'b1, 1'b0);
      repeat (3) stepCycle(word, 1'b0, 1'b0, 1'b1, 1'b0);
      checkValue("ireg", word, lastIreg);
      repeat (5) stepCycle(ordinaryWord(), 1'b1, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic disabledRound();
      int i;
      stepCycle(ordinaryWord(), 1'b1, 1'b1, 1'b0, 1'b0);
      for (i = 0; i < RoundCycles - 1; i++) begin
         stepCycle(ordinaryWord(), 1'b1, 1'($urandom), 1'b0, 1'b0);
         requireTrue(lastIreg != ibufPkg::intOp, "Interrupt injected while disabled");
      end
   endtask

   task automatic stallRound(input logic keepEna);
      stepCycle({SlowOps[2'($urandom)], 26'($urandom)}, 1'b1, 1'b0, 1'b0, 1'b1);
      // Execute stays on or drops after the slow op
      repeat (RoundCycles - 1) begin
         stepCycle(ordinaryWord(), $urandom_range(3) != 0, 1'b0, 1'b0, keepEna);
      end
   endtask

   initial begin : stimulus
      int i;
      void'($urandom(Seed));
      grst = 1'b1;
      iData = '0;
      sysInt = 1'b0;
      msrIe = 1'b0;
      dEn = 1'b0;
      oEna = 1'b0;
      lastIreg = '0;
      testName = "reset";
      repeat (ResetCycles) @(negedge gclk);
      grst = 1'b0;
      testName = "decode";
      repeat (DecodeCycles) begin
         stepCycle(ordinaryWord(), $urandom_range(3) != 0, 1'($urandom), 1'b0, 1'($urandom));
      end
      testName = "immPrefix";
      repeat (ImmPairs) begin
         stepCycle({ibufPkg::opImm, 26'($urandom)}, 1'b1, 1'b0, 1'b0, 1'b0);
         stepCycle(ordinaryWord(), 1'b1, 1'b0, 1'b0, 1'b0);
      end
      testName = "irqInject";
      repeat (IrqRounds) irqRound();
      testName = "irqBlocked";
      for (i = 0; i < 4; i++) begin
         blockRound(BlockOps[2'(i)]);
      end
      testName = "irqDisabled";
      repeat (IrqRounds) disabledRound();
      testName = "stall";
      for (i = 0; i < StallRounds; i++) begin
         stallRound((i % 2) == 0);
      end
      @(negedge gclk);
      checkOutputs();
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/ibuf_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module ibufAsserts (
   input logic                     gclk,
   input logic                     grst,
   input logic                     dEn,
   input logic                     oEna,
   input logic                     msrIe,
   input logic                     intPend,
   input logic [31:0]              iData,
   input logic [31:0]              ireg,
   input logic [ibufPkg::OpcW-1:0] opc,
   input logic [ibufPkg::RegW-1:0] rd,
   input logic [ibufPkg::RegW-1:0] ra,
   input logic [ibufPkg::ImmW-1:0] imm,
   input logic [31:0]              simm,
   input logic                     fStall
);

   logic isSlow;
   logic isBlocking;
   logic stallStart;
   logic injected;

   // Multiply and barrel-shift opcodes
   assign isSlow = opc == ibufPkg::opMul0 || opc == ibufPkg::opMul1
      || opc == ibufPkg::opBsf0 || opc == ibufPkg::opBsf1;
   // IMM pair, return, branch delay slots
   assign isBlocking = opc == ibufPkg::opImm || opc == ibufPkg::opRtd
      || opc == ibufPkg::opBru0 || opc == ibufPkg::opBru1
      || opc == ibufPkg::opBcc0 || opc == ibufPkg::opBcc1;
   // Slow op seen while the stall is idle
   assign stallStart = oEna & isSlow & ~fStall & ~grst;
   assign injected = dEn & (ireg == ibufPkg::intOp);

   resetClears: assert property (@(posedge gclk)
      $past(grst) |-> opc == '0 && rd == '0 && ra == '0 && imm == '0 && simm == '0 && !fStall)
      else $error("Decode fields or stall not cleared by reset");

   // Two stall cycles after the decode
   stallHeld: assert property (@(posedge gclk) disable iff (grst)
      $past(stallStart) || $past(stallStart, 2) |-> fStall)
      else $error("Stall not held for two cycles");

   // Third cycle free unless a new slow op arrived
   stallEnds: assert property (@(posedge gclk) disable iff (grst)
      $past(stallStart, 3) && !$past(oEna && isSlow) |-> !fStall)
      else $error("Stall lasted longer than two cycles");

   stallOff: assert property (@(posedge gclk) disable iff (grst)
      !$past(oEna) && !$past(oEna, 2) |-> !fStall)
      else $error("Stall still high two cycles after execute disable");

   // Request gone once the injected word is decoded
   injectOnce: assert property (@(posedge gclk) disable iff (grst)
      injected |-> ##2 !intPend)
      else $error("Interrupt still pending after its injection");

   injectBlocked: assert property (@(posedge gclk) disable iff (grst)
      isBlocking |-> ireg == iData)
      else $error("Injection into an IMM pair, return or delay slot");

   // Disabled interrupts never stay pending
   pendDisabled: assert property (@(posedge gclk) disable iff (grst)
      !$past(msrIe) |-> !intPend)
      else $error("Interrupt pending while interrupts disabled");

endmodule

bind ibufTop ibufAsserts uAsserts (.*);

`default_nettype wire

//--- design/ibufTop.sv
`timescale 1ns/100ps
`default_nettype none

module ibufTop #(
   parameter int SYNC_DEPTH = 2
) (
   input  logic                     gclk,
   input  logic                     grst,
   input  logic [31:0]              iData,
   input  logic                     sysInt,
   input  logic                     msrIe,
   input  logic                     dEn,
   input  logic                     oEna,
   output logic [ibufPkg::OpcW-1:0] opc,
   output logic [ibufPkg::RegW-1:0] rd,
   output logic [ibufPkg::RegW-1:0] ra,
   output logic [ibufPkg::RegW-1:0] rb,
   output logic [ibufPkg::AltW-1:0] alt,
   output logic [ibufPkg::ImmW-1:0] imm,
   output logic [31:0]              simm,
   output logic [31:0]              ireg,
   output logic                     fStall
);

   // Handshake between latch and decoder
   logic intPend;
   logic intTaken;

   irqLatch #(
      .SYNC_DEPTH(SYNC_DEPTH)
   ) uIrq (
      .gclk    (gclk),
      .grst    (grst),
      .sysInt  (sysInt),
      .msrIe   (msrIe),
      .intTaken(intTaken),
      .intPend (intPend)
   );

   instrDecode uDec (
      .gclk    (gclk),
      .grst    (grst),
      .dEn     (dEn),
      .intPend (intPend),
      .iData   (iData),
      .opc     (opc),
      .rd      (rd),
      .ra      (ra),
      .imm     (imm),
      .rb      (rb),
      .alt     (alt),
      .simm    (simm),
      .ireg    (ireg),
      .intTaken(intTaken)
   );

   // Stall follows the registered opcode
   stallGen uStall (
      .gclk  (gclk),
      .grst  (grst),
      .oEna  (oEna),
      .opc   (opc),
      .fStall(fStall)
   );

endmodule

`default_nettype wire

//--- design/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
   input  logic                     gclk,
   input  logic                     grst,
   // Decode enable, the only back-pressure
   input  logic                     dEn,
   // Interrupt waiting to be injected
   input  logic                     intPend,
   // Fetched instruction word
   input  logic [31:0]              iData,
   output logic [ibufPkg::OpcW-1:0] opc,
   output logic [ibufPkg::RegW-1:0] rd,
   output logic [ibufPkg::RegW-1:0] ra,
   output logic [ibufPkg::ImmW-1:0] imm,
   output logic [ibufPkg::RegW-1:0] rb,
   output logic [ibufPkg::AltW-1:0] alt,
   output logic [31:0]              simm,
   // Selected word ahead of the decode register
   output logic [31:0]              ireg,
   output logic                     intTaken
);

   // Decode registers
   logic [ibufPkg::OpcW-1:0] rOpc;
   logic [ibufPkg::RegW-1:0] rRd;
   logic [ibufPkg::RegW-1:0] rRa;
   logic [ibufPkg::ImmW-1:0] rImm;
   logic [31:0]              rSimm;

   // Registered word rebuilt from the fields
   logic [31:0] curWord;

   // Classes of the current opcode
   logic isImm;
   logic isRtd;
   logic isBru;
   logic isBcc;
   logic noInject;

   logic [31:0] selWord;
   logic [31:0] nextSimm;

   assign isImm = (rOpc == ibufPkg::opImm);
   assign isRtd = (rOpc == ibufPkg::opRtd);
   assign isBru = (rOpc == ibufPkg::opBru0) | (rOpc == ibufPkg::opBru1);
   assign isBcc = (rOpc == ibufPkg::opBcc0) | (rOpc == ibufPkg::opBcc1);

   // Keep IMM pairs together, never steal a delay slot
   assign noInject = isImm | isRtd | isBru | isBcc;

   // Swap in the branch-and-link while a request waits
   assign selWord = (intPend & ~noInject) ? ibufPkg::intOp : iData;

   // Prefix supplies the upper half
   // otherwise sign-extend the low 16 bits
   always_comb begin
      if (isImm) begin
         nextSimm = {rImm, selWord[15:0]};
      end else begin
         nextSimm = {{16{selWord[15]}}, selWord[15:0]};
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         rOpc  <= '0;
         rRd   <= '0;
         rRa   <= '0;
         rImm  <= '0;
         rSimm <= '0;
      end else if (dEn) begin
         {rOpc, rRd, rRa, rImm} <= selWord;
         rSimm <= nextSimm;
      end
   end

   assign curWord = {rOpc, rRd, rRa, rImm};

   // Injected word now in the decode register
   assign intTaken = (curWord == ibufPkg::intOp);

   assign opc  = rOpc;
   assign rd   = rRd;
   assign ra   = rRa;
   assign imm  = rImm;
   assign simm = rSimm;
   assign ireg = selWord;

   // rb and extended bits share the raw immediate
   assign rb  = rImm[ibufPkg::ImmW-1:ibufPkg::AltW];
   assign alt = rImm[ibufPkg::AltW-1:0];

endmodule

`default_nettype wire

//--- design/stallGen.sv
`timescale 1ns/100ps
`default_nettype none

module stallGen (
   input  logic                     gclk,
   input  logic                     grst,
   // Execute stage enable level
   input  logic                     oEna,
   // Registered opcode from the decoder
   input  logic [ibufPkg::OpcW-1:0] opc,
   output logic                     fStall
);

   logic isMul;
   logic isBsf;
   logic rStall;
   logic rStallDly;

   // Multiply and barrel-shift need two extra cycles
   assign isMul = (opc == ibufPkg::opMul0) | (opc == ibufPkg::opMul1);
   assign isBsf = (opc == ibufPkg::opBsf0) | (opc == ibufPkg::opBsf1);

   always_ff @(posedge gclk) begin
      if (grst) begin
         rStall    <= 1'b0;
         rStallDly <= 1'b0;
      end else begin
         rStallDly <= rStall;
         // No retrigger while already stalling
         if (oEna) begin
            rStall <= ~rStall & (isMul | isBsf);
         end else begin
            rStall <= 1'b0;
         end
      end
   end

   // Stall and its delayed copy give the two-cycle window
   assign fStall = rStall | rStallDly;

endmodule

`default_nettype wire

//--- design/irqLatch.sv
`timescale 1ns/100ps
`default_nettype none

module irqLatch #(
   parameter int SYNC_DEPTH = 2
) (
   input  logic gclk,
   input  logic grst,
   // Raw external interrupt, asynchronous to gclk
   input  logic sysInt,
   // Interrupt enable from the status register
   input  logic msrIe,
   // Injected word reached the decode register
   input  logic intTaken,
   output logic intPend
);

   // Synchronizer chain, newest sample in bit 0
   logic [SYNC_DEPTH-1:0] rSync;
   logic                  rPend;
   logic                  shot;

   // Oldest stage fires the pending flag
   assign shot = rSync[SYNC_DEPTH-1];

   always_ff @(posedge gclk) begin
      if (grst) begin
         rSync <= '0;
         rPend <= 1'b0;
      end else begin
         // Sample only while interrupts are enabled
         if (msrIe) begin
            rSync <= {rSync[SYNC_DEPTH-2:0], sysInt};
         end
         // Sticky until the injection is seen
         if (intTaken) begin
            rPend <= 1'b0;
         end else begin
            // Disable drops the request at once
            rPend <= (rPend | shot) & msrIe;
         end
      end
   end

   assign intPend = rPend;

endmodule

`default_nettype wire

//--- design/ibufPkg.sv
`default_nettype none

package ibufPkg;

   // Instruction field widths
   localparam int OpcW = 6;
   localparam int RegW = 5;
   localparam int ImmW = 16;
   // Extended bits below rb in the raw immediate
   localparam int AltW = 11;

   // Immediate prefix and return
   localparam logic [OpcW-1:0] opImm = 6'o54;
   localparam logic [OpcW-1:0] opRtd = 6'o55;

   // Unconditional branches
   localparam logic [OpcW-1:0] opBru0 = 6'o46;
   localparam logic [OpcW-1:0] opBru1 = 6'o56;

   // Conditional branches
   localparam logic [OpcW-1:0] opBcc0 = 6'o47;
   localparam logic [OpcW-1:0] opBcc1 = 6'o57;

   // Multi-cycle execute ops
   localparam logic [OpcW-1:0] opMul0 = 6'o20;
   localparam logic [OpcW-1:0] opMul1 = 6'o30;
   localparam logic [OpcW-1:0] opBsf0 = 6'o21;
   localparam logic [OpcW-1:0] opBsf1 = 6'o31;

   // Branch-and-link to vector 0x40
   // Link register r30, base r12
   localparam logic [31:0] intOp = {
      6'o56,
      5'h1e,
      5'h0c,
      16'h0040
   };

endpackage

`default_nettype wire
